// ==== verilog/mmu_addr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// 32-bit MIPS segment map and the CP0 Status/Config fields the MMU reads
// only K0/KU/K23 cacheability is modelled, other CCA codes mean uncached
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mmu_addr_pkg;

    // datapath widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;   // one write enable per byte

    // top address bits that pick the segment
    localparam int SEG_MSB_W = 3;

    typedef enum logic [1:0] {
        SEG_KUSEG,   // 0x0000_0000, mapped user space
        SEG_KSEG0,   // 0x8000_0000, unmapped, cache per K0
        SEG_KSEG1,   // 0xa000_0000, unmapped, uncached
        SEG_KSEG23   // 0xc000_0000, mapped kernel space
    } seg_e;

    // Status register
    localparam int STATUS_ERL_BIT = 2;   // error level, forces unmapped

    // Config register, each cache-coherency field is CCA_W bits
    localparam int CCA_W          = 3;
    localparam int CONFIG_K0_LSB  = 0;
    localparam int CONFIG_KU_LSB  = 25;
    localparam int CONFIG_K23_LSB = 28;

    // cacheable, noncoherent, write-back
    localparam logic [CCA_W-1:0] CCA_CACHED = 3'd3;

endpackage

`default_nettype wire

// ==== verilog/mmu_tlb_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// TLB geometry and exception codes
// fixed 4 KB pages, one frame per entry, no ASID
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mmu_tlb_pkg;

    // page geometry
    localparam int PAGE_OFS_W = 12;   // 4 KB
    localparam int VPN_W      = mmu_addr_pkg::ADDR_W - PAGE_OFS_W;
    localparam int PFN_W      = 20;

    // translation exceptions, reported back with the response
    typedef enum logic [1:0] {
        EXC_NONE,       // translated or unmapped
        EXC_REFILL,     // no entry holds the VPN
        EXC_INVALID,    // entry found but V clear
        EXC_MODIFIED    // store to an entry with D clear
    } exc_e;

endpackage

`default_nettype wire

// ==== verilog/mmu_seg_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// CP0 Status and Config are sampled with the request
// mapped items take their cacheability from the TLB
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mmu_seg_decode (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              req_valid,
    output logic                             req_ready,
    input  wire [mmu_addr_pkg::ADDR_W-1:0]   req_vaddr,
    input  wire [mmu_addr_pkg::BE_W-1:0]     req_wen,
    input  wire [mmu_addr_pkg::DATA_W-1:0]   req_wdata,
    input  wire [31:0]                       cp0_status,
    input  wire [31:0]                       cp0_config,
    output logic                             dec_valid,
    input  wire                              dec_ready,
    output logic [mmu_addr_pkg::ADDR_W-1:0]  dec_vaddr,
    output logic [mmu_addr_pkg::BE_W-1:0]    dec_wen,
    output logic [mmu_addr_pkg::DATA_W-1:0]  dec_wdata,
    output logic                             dec_mapped,
    output logic [mmu_addr_pkg::ADDR_W-1:0]  dec_paddr,
    output logic                             dec_cached
);

    localparam int AW = mmu_addr_pkg::ADDR_W;
    localparam int SW = mmu_addr_pkg::SEG_MSB_W;

    mmu_addr_pkg::seg_e                seg;
    logic [mmu_addr_pkg::CCA_W-1:0]    k0;
    logic                              erl;
    logic                              mapped;
    logic                              cached;
    logic [AW-1:0]                     low_paddr;
    logic                              out_of_reset;

    assign erl       = cp0_status[mmu_addr_pkg::STATUS_ERL_BIT];
    assign k0        = cp0_config[mmu_addr_pkg::CONFIG_K0_LSB +: mmu_addr_pkg::CCA_W];
    assign low_paddr = {{SW{1'b0}}, req_vaddr[AW-SW-1:0]};   // strip segment bits

    always_comb begin
        case (req_vaddr[AW-1 -: SW])
            3'b100:  seg = mmu_addr_pkg::SEG_KSEG0;
            3'b101:  seg = mmu_addr_pkg::SEG_KSEG1;
            3'b110,
            3'b111:  seg = mmu_addr_pkg::SEG_KSEG23;
            default: seg = mmu_addr_pkg::SEG_KUSEG;
        endcase
    end

    always_comb begin
        mapped = 1'b0;
        cached = 1'b0;
        case (seg)
            mmu_addr_pkg::SEG_KSEG0:  cached = (k0 == mmu_addr_pkg::CCA_CACHED);
            mmu_addr_pkg::SEG_KSEG1:  cached = 1'b0;   // always uncached
            default: begin
                mapped = !erl;   // ERL turns kuseg and kseg2/3 into an uncached window
            end
        endcase
    end

    // holds req_ready low until the first edge after reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_of_reset <= 1'b0;
            dec_valid    <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
            if (req_ready) begin
                dec_valid <= req_valid;
            end
        end
    end

    assign req_ready = out_of_reset && (!dec_valid || dec_ready);

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            dec_vaddr  <= req_vaddr;
            dec_wen    <= req_wen;
            dec_wdata  <= req_wdata;
            dec_mapped <= mapped;
            dec_paddr  <= low_paddr;   // replaced in execute when mapped
            dec_cached <= cached;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mmu_tlb_lookup.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// fully associative TLB, do not write it while a mapped item is in this stage
// on a double match the lowest index wins
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mmu_tlb_lookup #(
    parameter  int TLB_ENTRIES = 8,
    localparam int IDX_W       = $clog2(TLB_ENTRIES)
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              dec_valid,
    output logic                             dec_ready,
    input  wire [mmu_addr_pkg::ADDR_W-1:0]   dec_vaddr,
    input  wire [mmu_addr_pkg::BE_W-1:0]     dec_wen,
    input  wire [mmu_addr_pkg::DATA_W-1:0]   dec_wdata,
    input  wire                              dec_mapped,
    input  wire [mmu_addr_pkg::ADDR_W-1:0]   dec_paddr,
    input  wire                              dec_cached,
    output logic                             exe_valid,
    input  wire                              exe_ready,
    output logic [mmu_addr_pkg::ADDR_W-1:0]  exe_paddr,
    output logic                             exe_cached,
    output logic [mmu_addr_pkg::BE_W-1:0]    exe_wen,
    output logic [mmu_addr_pkg::DATA_W-1:0]  exe_wdata,
    output mmu_tlb_pkg::exc_e                exe_exc,
    input  wire                              tlbw_valid,
    input  wire [IDX_W-1:0]                  tlbw_index,
    input  wire [mmu_tlb_pkg::VPN_W-1:0]     tlbw_vpn,
    input  wire [mmu_tlb_pkg::PFN_W-1:0]     tlbw_pfn,
    input  wire                              tlbw_v,
    input  wire                              tlbw_d,
    input  wire                              tlbw_c
);

    localparam int OFS_W = mmu_tlb_pkg::PAGE_OFS_W;

    // entry storage
    logic [mmu_tlb_pkg::VPN_W-1:0]  tlb_vpn [TLB_ENTRIES];
    logic [mmu_tlb_pkg::PFN_W-1:0]  tlb_pfn [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0]         tag_valid;   // entry has been written
    logic [TLB_ENTRIES-1:0]         tlb_v;
    logic [TLB_ENTRIES-1:0]         tlb_d;
    logic [TLB_ENTRIES-1:0]         tlb_c;

    logic [mmu_tlb_pkg::VPN_W-1:0]  dec_vpn;
    logic                           hit;
    logic [IDX_W-1:0]               hit_idx;
    logic                           is_store;
    logic [mmu_addr_pkg::ADDR_W-1:0] paddr;
    logic                           cached;
    mmu_tlb_pkg::exc_e              exc;

    assign dec_vpn  = dec_vaddr[mmu_addr_pkg::ADDR_W-1:OFS_W];
    assign is_store = |dec_wen;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_valid <= '0;
        end else if (tlbw_valid) begin
            tag_valid[tlbw_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbw_valid) begin
            tlb_vpn[tlbw_index] <= tlbw_vpn;
            tlb_pfn[tlbw_index] <= tlbw_pfn;
            tlb_v[tlbw_index]   <= tlbw_v;
            tlb_d[tlbw_index]   <= tlbw_d;
            tlb_c[tlbw_index]   <= tlbw_c;
        end
    end

    // parallel compare, scanned downward so the lowest index is kept
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (tag_valid[i] && (tlb_vpn[i] == dec_vpn)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        exc    = mmu_tlb_pkg::EXC_NONE;
        paddr  = dec_paddr;
        cached = dec_cached;
        if (dec_mapped) begin
            if (!hit) begin
                exc = mmu_tlb_pkg::EXC_REFILL;
            end else if (!tlb_v[hit_idx]) begin
                exc = mmu_tlb_pkg::EXC_INVALID;
            end else if (is_store && !tlb_d[hit_idx]) begin
                exc = mmu_tlb_pkg::EXC_MODIFIED;
            end else begin
                paddr  = {tlb_pfn[hit_idx], dec_vaddr[OFS_W-1:0]};
                cached = tlb_c[hit_idx];
            end
        end
    end

    assign dec_ready = !exe_valid || exe_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_valid <= 1'b0;
        end else if (dec_ready) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            exe_paddr  <= paddr;
            exe_cached <= cached;
            exe_wen    <= dec_wen;
            exe_wdata  <= dec_wdata;
            exe_exc    <= exc;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mmu_access_result.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// one bus transaction in flight, bus must answer every accepted request once
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mmu_access_result (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              exe_valid,
    output logic                             exe_ready,
    input  wire [mmu_addr_pkg::ADDR_W-1:0]   exe_paddr,
    input  wire                              exe_cached,
    input  wire [mmu_addr_pkg::BE_W-1:0]     exe_wen,
    input  wire [mmu_addr_pkg::DATA_W-1:0]   exe_wdata,
    input  wire mmu_tlb_pkg::exc_e           exe_exc,
    output logic                             bus_valid,
    input  wire                              bus_ready,
    output logic [mmu_addr_pkg::ADDR_W-1:0]  bus_paddr,
    output logic [mmu_addr_pkg::BE_W-1:0]    bus_wen,
    output logic [mmu_addr_pkg::DATA_W-1:0]  bus_wdata,
    output logic                             bus_cached,
    input  wire                              bus_rvalid,
    input  wire [mmu_addr_pkg::DATA_W-1:0]   bus_rdata,
    output logic                             rsp_valid,
    input  wire                              rsp_ready,
    output logic [mmu_addr_pkg::DATA_W-1:0]  rsp_rdata,
    output mmu_tlb_pkg::exc_e                rsp_exc
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS_REQ,
        ST_WAIT_DATA,
        ST_RESP
    } state_e;

    state_e state;
    state_e st_accept;
    logic   accept;
    logic   take_data;
    logic   is_store;

    assign exe_ready = (state == ST_IDLE) || ((state == ST_RESP) && rsp_ready);
    assign accept    = exe_valid && exe_ready;
    assign st_accept = (exe_exc == mmu_tlb_pkg::EXC_NONE) ? ST_BUS_REQ : ST_RESP;
    assign bus_valid = (state == ST_BUS_REQ);
    assign rsp_valid = (state == ST_RESP);
    assign is_store  = |bus_wen;

    // read data may come back on the same edge the request is taken
    assign take_data = bus_rvalid && ((state == ST_WAIT_DATA) ||
                                      ((state == ST_BUS_REQ) && bus_ready));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) state <= st_accept;
                end
                ST_BUS_REQ: begin
                    if (take_data) state <= ST_RESP;
                    else if (bus_ready) state <= ST_WAIT_DATA;
                end
                ST_WAIT_DATA: begin
                    if (take_data) state <= ST_RESP;
                end
                default: begin
                    if (accept) state <= st_accept;   // back-to-back item
                    else if (rsp_ready) state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus_paddr  <= exe_paddr;
            bus_wen    <= exe_wen;
            bus_wdata  <= exe_wdata;
            bus_cached <= exe_cached;
            rsp_exc    <= exe_exc;
            rsp_rdata  <= '0;   // stays zero for stores and exceptions
        end else if (take_data && !is_store) begin
            rsp_rdata  <= bus_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mmu_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// data-side MMU, decode -> TLB -> bus, one item per stage
// TLB_ENTRIES must be a power of two from 2 to 32
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mmu_top #(
    parameter  int TLB_ENTRIES = 8,
    localparam int IDX_W       = $clog2(TLB_ENTRIES)
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire                              req_valid,
    output logic                             req_ready,
    input  wire [mmu_addr_pkg::ADDR_W-1:0]   req_vaddr,
    input  wire [mmu_addr_pkg::BE_W-1:0]     req_wen,
    input  wire [mmu_addr_pkg::DATA_W-1:0]   req_wdata,
    output logic                             rsp_valid,
    input  wire                              rsp_ready,
    output logic [mmu_addr_pkg::DATA_W-1:0]  rsp_rdata,
    output mmu_tlb_pkg::exc_e                rsp_exc,
    input  wire [31:0]                       cp0_status,
    input  wire [31:0]                       cp0_config,
    input  wire                              tlbw_valid,
    input  wire [IDX_W-1:0]                  tlbw_index,
    input  wire [mmu_tlb_pkg::VPN_W-1:0]     tlbw_vpn,
    input  wire [mmu_tlb_pkg::PFN_W-1:0]     tlbw_pfn,
    input  wire                              tlbw_v,
    input  wire                              tlbw_d,
    input  wire                              tlbw_c,
    output logic                             bus_valid,
    input  wire                              bus_ready,
    output logic [mmu_addr_pkg::ADDR_W-1:0]  bus_paddr,
    output logic [mmu_addr_pkg::BE_W-1:0]    bus_wen,
    output logic [mmu_addr_pkg::DATA_W-1:0]  bus_wdata,
    output logic                             bus_cached,
    input  wire                              bus_rvalid,
    input  wire [mmu_addr_pkg::DATA_W-1:0]   bus_rdata
);

    // decode -> execute
    logic                             dec_valid;
    logic                             dec_ready;
    logic [mmu_addr_pkg::ADDR_W-1:0]  dec_vaddr;
    logic [mmu_addr_pkg::BE_W-1:0]    dec_wen;
    logic [mmu_addr_pkg::DATA_W-1:0]  dec_wdata;
    logic                             dec_mapped;
    logic [mmu_addr_pkg::ADDR_W-1:0]  dec_paddr;
    logic                             dec_cached;

    // execute -> result
    logic                             exe_valid;
    logic                             exe_ready;
    logic [mmu_addr_pkg::ADDR_W-1:0]  exe_paddr;
    logic                             exe_cached;
    logic [mmu_addr_pkg::BE_W-1:0]    exe_wen;
    logic [mmu_addr_pkg::DATA_W-1:0]  exe_wdata;
    mmu_tlb_pkg::exc_e                exe_exc;

    mmu_seg_decode i_seg_decode (
        .clk, .arst_n,
        .req_valid, .req_ready, .req_vaddr, .req_wen, .req_wdata,
        .cp0_status, .cp0_config,
        .dec_valid, .dec_ready, .dec_vaddr, .dec_wen, .dec_wdata,
        .dec_mapped, .dec_paddr, .dec_cached
    );

    mmu_tlb_lookup #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_tlb_lookup (
        .clk, .arst_n,
        .dec_valid, .dec_ready, .dec_vaddr, .dec_wen, .dec_wdata,
        .dec_mapped, .dec_paddr, .dec_cached,
        .exe_valid, .exe_ready, .exe_paddr, .exe_cached, .exe_wen, .exe_wdata, .exe_exc,
        .tlbw_valid, .tlbw_index, .tlbw_vpn, .tlbw_pfn, .tlbw_v, .tlbw_d, .tlbw_c
    );

    mmu_access_result i_access_result (
        .clk, .arst_n,
        .exe_valid, .exe_ready, .exe_paddr, .exe_cached, .exe_wen, .exe_wdata, .exe_exc,
        .bus_valid, .bus_ready, .bus_paddr, .bus_wen, .bus_wdata, .bus_cached,
        .bus_rvalid, .bus_rdata,
        .rsp_valid, .rsp_ready, .rsp_rdata, .rsp_exc
    );

endmodule

`default_nettype wire

// ==== verification/mmu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// directed tests for mmu_top with a one-outstanding bus memory model
// memory is 1024 words, so only paddr[11:2] selects a word
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mmu_tb;

    localparam int TLB_ENTRIES = 8;
    localparam int IDX_W       = $clog2(TLB_ENTRIES);
    localparam int TIMEOUT     = 200;            // cycles per wait
    localparam logic [31:0] SEED = 32'h5c007de0;

    logic                               clk = 1'b0;
    logic                               arst_n;
    logic                               req_valid;
    logic                               req_ready;
    logic [mmu_addr_pkg::ADDR_W-1:0]    req_vaddr;
    logic [mmu_addr_pkg::BE_W-1:0]      req_wen;
    logic [mmu_addr_pkg::DATA_W-1:0]    req_wdata;
    logic                               rsp_valid;
    logic                               rsp_ready;
    logic [mmu_addr_pkg::DATA_W-1:0]    rsp_rdata;
    mmu_tlb_pkg::exc_e                  rsp_exc;
    logic [31:0]                        cp0_status;
    logic [31:0]                        cp0_config;
    logic                               tlbw_valid;
    logic [IDX_W-1:0]                   tlbw_index;
    logic [mmu_tlb_pkg::VPN_W-1:0]      tlbw_vpn;
    logic [mmu_tlb_pkg::PFN_W-1:0]      tlbw_pfn;
    logic                               tlbw_v;
    logic                               tlbw_d;
    logic                               tlbw_c;
    logic                               bus_valid;
    logic                               bus_ready;
    logic [mmu_addr_pkg::ADDR_W-1:0]    bus_paddr;
    logic [mmu_addr_pkg::BE_W-1:0]      bus_wen;
    logic [mmu_addr_pkg::DATA_W-1:0]    bus_wdata;
    logic                               bus_cached;
    logic                               bus_rvalid;
    logic [mmu_addr_pkg::DATA_W-1:0]    bus_rdata;

    // bus model state
    logic [31:0]  mem [1024];
    logic         bus_pending;
    int           bus_delay;
    logic [9:0]   bus_idx;
    int           bus_count;     // accepted bus requests so far
    logic [31:0]  last_paddr;
    logic         last_cached;

    // test bookkeeping
    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    logic [31:0]        test_rng;
    logic [31:0]        got_rdata;
    mmu_tlb_pkg::exc_e  got_exc;
    logic               saw_bus_valid;
    int                 bus_seen;
    logic [31:0]        kseg0_word;

    mmu_top #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_mmu_top (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // initial memory contents, every word differs
    function automatic logic [31:0] fill_word(input logic [9:0] idx);
        return {6'h2a, idx, 6'h15, ~idx};
    endfunction

    function automatic logic [31:0] make_config(input logic [2:0] k0, input logic [2:0] ku,
                                                input logic [2:0] k23);
        logic [31:0] c;
        c = '0;
        c[mmu_addr_pkg::CONFIG_K0_LSB +: 3]  = k0;
        c[mmu_addr_pkg::CONFIG_KU_LSB +: 3]  = ku;
        c[mmu_addr_pkg::CONFIG_K23_LSB +: 3] = k23;
        return c;
    endfunction

    // memory answers each accepted request 0 to 3 cycles later
    initial begin : bus_model
        logic [31:0] bus_rng;
        bus_rng     = SEED;
        bus_ready   = 1'b0;
        bus_rvalid  = 1'b0;
        bus_rdata   = '0;
        bus_pending = 1'b0;
        bus_delay   = 0;
        bus_count   = 0;
        bus_idx     = '0;
        last_paddr  = '0;
        last_cached = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(10'(i));
        end
        forever begin
            @(negedge clk);
            if (bus_valid && bus_ready) begin
                bus_idx = bus_paddr[11:2];
                for (int b = 0; b < 4; b++) begin
                    if (bus_wen[b]) mem[bus_idx][8*b +: 8] = bus_wdata[8*b +: 8];
                end
                last_paddr  = bus_paddr;
                last_cached = bus_cached;
                bus_count++;
                bus_rng     = xorshift(bus_rng);
                bus_delay   = int'(bus_rng % 32'd4);
                bus_pending = 1'b1;
            end
            @(posedge clk);
            #1;
            bus_rvalid = 1'b0;
            if (bus_pending && bus_delay == 0) begin
                bus_rvalid  = 1'b1;
                bus_rdata   = mem[bus_idx];
                bus_pending = 1'b0;
            end else if (bus_pending) begin
                bus_delay--;
            end
            bus_rng   = xorshift(bus_rng);
            bus_ready = !bus_pending && (bus_rng[9:8] != 2'b00);   // busy a quarter of the time
        end
    end

    task automatic finish_run();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout: no %s within %0d cycles", what, TIMEOUT);
        finish_run();
    endtask

    task automatic send_request(input logic [31:0] vaddr, input logic [3:0] wen,
                                input logic [31:0] wdata);
        int   cycles;
        logic taken;
        cycles    = 0;
        taken     = 1'b0;
        req_valid = 1'b1;
        req_vaddr = vaddr;
        req_wen   = wen;
        req_wdata = wdata;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
            cycles++;
            if (!taken && cycles > TIMEOUT) report_timeout("req_ready");
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_response();
        int   cycles;
        logic done;
        cycles        = 0;
        done          = 1'b0;
        saw_bus_valid = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (bus_valid) saw_bus_valid = 1'b1;
            done = rsp_valid && rsp_ready;
            if (done) begin
                got_rdata = rsp_rdata;
                got_exc   = rsp_exc;
            end
            @(posedge clk);
            #1;
            cycles++;
            if (!done && cycles > TIMEOUT) report_timeout("rsp_valid");
        end
    endtask

    task automatic do_access(input logic [31:0] vaddr, input logic [3:0] wen,
                             input logic [31:0] wdata);
        int start_count;
        start_count = bus_count;
        send_request(vaddr, wen, wdata);
        wait_response();
        bus_seen = bus_count - start_count;
    endtask

    task automatic write_tlb(input logic [IDX_W-1:0] idx, input logic [19:0] vpn,
                             input logic [19:0] pfn, input logic v, input logic d,
                             input logic c);
        tlbw_valid = 1'b1;
        tlbw_index = idx;
        tlbw_vpn   = vpn;
        tlbw_pfn   = pfn;
        tlbw_v     = v;
        tlbw_d     = d;
        tlbw_c     = c;
        @(posedge clk);
        #1;
        tlbw_valid = 1'b0;
    endtask

    task automatic check_response(input string what, input mmu_tlb_pkg::exc_e exp_exc,
                                  input logic [31:0] exp_rdata);
        if (got_exc !== exp_exc) begin
            $display("MISMATCH rsp_exc (%s): got %h expected %h", what, got_exc, exp_exc);
            errors++;
        end
        if (got_rdata !== exp_rdata) begin
            $display("MISMATCH rsp_rdata (%s): got %h expected %h", what, got_rdata, exp_rdata);
            errors++;
        end
    endtask

    task automatic check_bus(input string what, input logic [31:0] exp_paddr,
                             input logic exp_cached);
        if (bus_seen != 1) begin
            $display("%s: expected one bus transaction but saw %0d", what, bus_seen);
            errors++;
        end
        if (last_paddr !== exp_paddr) begin
            $display("MISMATCH bus_paddr (%s): got %h expected %h", what, last_paddr, exp_paddr);
            errors++;
        end
        if (last_cached !== exp_cached) begin
            $display("MISMATCH bus_cached (%s): got %h expected %h", what, last_cached,
                     exp_cached);
            errors++;
        end
    endtask

    task automatic check_no_bus(input string what);
        if (saw_bus_valid || bus_seen != 0) begin
            $display("%s: a bus request was made for an exception", what);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int start);
        tests_run++;
        if (errors != start) begin
            tests_failed++;
            $display("%s: %0d error(s)", name, errors - start);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic test_kseg0();
        int          start;
        logic [2:0]  k0;
        logic [31:0] vaddr;
        logic [31:0] data;
        logic        exp_cached;
        start = errors;
        for (int pass = 0; pass < 2; pass++) begin
            k0         = (pass == 0) ? 3'd3 : 3'd2;
            vaddr      = 32'h8000_0140 + 32'(pass * 64);
            data       = 32'hc0de_0000 | 32'(k0);
            exp_cached = (k0 == 3'd3);
            cp0_config = make_config(k0, 3'd2, 3'd2);
            do_access(vaddr, 4'hf, data);
            check_response("kseg0 store", mmu_tlb_pkg::EXC_NONE, '0);
            check_bus("kseg0 store", vaddr & 32'h1fff_ffff, exp_cached);
            do_access(vaddr, 4'h0, '0);
            check_response("kseg0 load", mmu_tlb_pkg::EXC_NONE, data);
            check_bus("kseg0 load", vaddr & 32'h1fff_ffff, exp_cached);
            if (pass == 0) kseg0_word = data;
        end
        end_test("kseg0 store/load", start);
    endtask

    task automatic test_kseg1();
        int start;
        start      = errors;
        cp0_config = make_config(3'd3, 3'd3, 3'd3);   // kseg1 ignores K0
        do_access(32'ha000_0140, 4'h0, '0);
        check_response("kseg1 load", mmu_tlb_pkg::EXC_NONE, kseg0_word);
        check_bus("kseg1 load", 32'h0000_0140, 1'b0);
        end_test("kseg1 load", start);
    endtask

    task automatic test_tlb_translate();
        int          start;
        logic [31:0] vaddr;
        logic [31:0] paddr;
        start      = errors;
        vaddr      = {20'h00401, 12'h230};
        paddr      = {20'h00035, 12'h230};
        cp0_config = make_config(3'd2, 3'd2, 3'd2);
        write_tlb(IDX_W'(2), 20'h00401, 20'h00035, 1'b1, 1'b1, 1'b1);
        do_access(vaddr, 4'hf, 32'h1234_5678);
        check_response("tlb store", mmu_tlb_pkg::EXC_NONE, '0);
        check_bus("tlb store", paddr, 1'b1);
        do_access(vaddr, 4'h0, '0);
        check_response("tlb load", mmu_tlb_pkg::EXC_NONE, 32'h1234_5678);
        check_bus("tlb load", paddr, 1'b1);
        end_test("tlb translation", start);
    endtask

    task automatic test_exceptions();
        int start;
        start = errors;
        do_access({20'h00500, 12'h010}, 4'h0, '0);
        check_response("refill", mmu_tlb_pkg::EXC_REFILL, '0);
        check_no_bus("refill");
        write_tlb(IDX_W'(3), 20'h00600, 20'h00060, 1'b0, 1'b1, 1'b1);
        do_access({20'h00600, 12'h010}, 4'h0, '0);
        check_response("invalid", mmu_tlb_pkg::EXC_INVALID, '0);
        check_no_bus("invalid");
        write_tlb(IDX_W'(4), 20'h00700, 20'h00070, 1'b1, 1'b0, 1'b1);
        do_access({20'h00700, 12'h020}, 4'hf, 32'hdead_beef);
        check_response("modified", mmu_tlb_pkg::EXC_MODIFIED, '0);
        check_no_bus("modified");
        end_test("tlb exceptions", start);
    endtask

    task automatic test_erl();
        int start;
        start      = errors;
        cp0_status = 32'd1 << mmu_addr_pkg::STATUS_ERL_BIT;
        cp0_config = make_config(3'd2, 3'd3, 3'd3);   // K23 cached, ERL still wins
        do_access(32'hc000_0200, 4'h0, '0);
        check_response("erl kseg2 load", mmu_tlb_pkg::EXC_NONE, fill_word(10'h080));
        check_bus("erl kseg2 load", 32'h0000_0200, 1'b0);
        cp0_status = '0;
        end_test("erl unmapped", start);
    endtask

    task automatic test_backpressure();
        int start;
        int hold;
        start      = errors;
        cp0_config = make_config(3'd2, 3'd2, 3'd2);
        rsp_ready  = 1'b0;
        for (int k = 0; k < 3; k++) begin
            send_request(32'ha000_0300 + 32'(4 * k), 4'h0, '0);
        end
        test_rng = xorshift(test_rng);
        hold     = int'(test_rng % 32'd16) + 4;
        repeat (hold) @(posedge clk);
        @(negedge clk);
        if (req_ready !== 1'b0) begin
            $display("MISMATCH req_ready (stages full): got %h expected %h", req_ready, 1'b0);
            errors++;
        end
        @(posedge clk);
        #1;
        rsp_ready = 1'b1;
        for (int k = 0; k < 3; k++) begin
            wait_response();
            check_response($sformatf("back-pressure load %0d", k), mmu_tlb_pkg::EXC_NONE,
                           fill_word(10'h0c0 + 10'(k)));
        end
        end_test("back-pressure", start);
    endtask

    initial begin
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req_vaddr    = '0;
        req_wen      = '0;
        req_wdata    = '0;
        rsp_ready    = 1'b1;
        cp0_status   = '0;
        cp0_config   = make_config(3'd2, 3'd2, 3'd2);
        tlbw_valid   = 1'b0;
        tlbw_index   = '0;
        tlbw_vpn     = '0;
        tlbw_pfn     = '0;
        tlbw_v       = 1'b0;
        tlbw_d       = 1'b0;
        tlbw_c       = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_rng     = SEED;
        kseg0_word   = '0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_kseg0();
        test_kseg1();
        test_tlb_translate();
        test_exceptions();
        test_erl();
        test_backpressure();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/mmu_addr_pkg.sv
verilog/mmu_tlb_pkg.sv
verilog/mmu_seg_decode.sv
verilog/mmu_tlb_lookup.sv
verilog/mmu_access_result.sv
verilog/mmu_top.sv
verification/mmu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the MMU testbench with Verilator, run it, judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module mmu_tb \
    -f sources.f \
    -o mmu_sim

./obj_dir/mmu_sim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
